// File: files.f
+incdir+test
verilog/ghash_pkg.sv
verilog/gf128_mult.sv
verilog/h_key_power_table.sv
verilog/ghash_core.sv
verilog/ghash_regs.sv
verilog/ghash_top.sv
test/ghash_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the GHASH testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module ghash_tb \
    -f files.f

# The simulator output goes to a log, the verdict comes from the log.
./obj_dir/Vghash_tb 2>&1 | tee sim.log

if grep -q "All checks passed" sim.log; then
    echo "Simulation result: PASS"
    exit 0
else
    echo "Simulation result: FAIL"
    exit 1
fi

// File: test/ghash_model.svh
`ifndef GHASH_MODEL_SVH
`define GHASH_MODEL_SVH

// Bit serial GF(2^128) multiply in GCM bit order.
// Word bit 127 is the x^0 coefficient.
function automatic block_t gf_mult(input block_t x, input block_t y);
    block_t z;
    block_t v;
    z = '0;
    v = y;
    for (int i = 0; i < NB_BLOCK; i++)
    begin
        if (x[NB_BLOCK-1-i])
        begin
            z = z ^ v;
        end
        // Times x, then reduce by R = 0xE1 followed by zeros.
        if (v[0])
        begin
            v = (v >> 1) ^ {8'he1, 120'h0};
        end
        else
        begin
            v = v >> 1;
        end
    end
    return z;
endfunction

// One APB transfer.
// Setup and access phases with the response sampled mid-cycle.
task automatic apb_access(input logic wr, input logic [NB_APB_ADDR-1:0] addr,
                          input logic [NB_APB_DATA-1:0] wdata,
                          output logic [NB_APB_DATA-1:0] rdata, output logic err);
    @(posedge clock);
    #DRIVE_DELAY;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clock);
    #DRIVE_DELAY;
    apb_req.penable = 1'b1;
    @(negedge clock);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    // No wait states on any access.
    check_word("pready", 32'd1, NB_APB_DATA'(apb_rsp.pready));
    // Transfer completes on this edge.
    @(posedge clock);
    #DRIVE_DELAY;
    apb_req = '0;
endtask

task automatic apb_write(input logic [NB_APB_ADDR-1:0] addr,
                         input logic [NB_APB_DATA-1:0] data, output logic err);
    logic [NB_APB_DATA-1:0] rdata;
    apb_access(1'b1, addr, data, rdata, err);
endtask

task automatic apb_read(input logic [NB_APB_ADDR-1:0] addr,
                        output logic [NB_APB_DATA-1:0] data, output logic err);
    apb_access(1'b0, addr, '0, data, err);
endtask

`endif

// File: test/ghash_tb.sv
`timescale 1ns/1ns

module ghash_tb
    import ghash_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DELAY  = 1;
    localparam int NROWS        = 12;
    localparam int POLL_LIMIT   = 16;
    // Worst row is under 30 APB transfers of 3 cycles.
    localparam int ROW_CYCLES   = 100;
    localparam int WD_CYCLES    = NROWS * ROW_CYCLES + 200;
    // GCM unit element has x^0 in word bit 127.
    localparam block_t KEY_ONE  = {1'b1, 127'b0};

    // One table row with the model's expected result.
    typedef struct packed {
        block_t key;
        block_t x1;
        block_t x2;
        logic   load;
        logic   clear;
        block_t exp;
    } row_t;

    logic     clock;
    logic     arst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    row_t     rows [NROWS];
    integer   seed;
    int       errors;
    int       checks;
    int       tests;
    int       test_errs;
    string    test_name;

    `include "ghash_model.svh"

    ghash_top dut_i
    (
        .o_apb    (apb_rsp),
        .i_apb    (apb_req),
        .i_arst_n (arst_n),
        .i_clock  (clock)
    );

    initial
    begin
        clock = 1'b0;
        forever #(CLK_PERIOD/2) clock = ~clock;
    end

    // Hard stop if a poll or the DUT stalls.
    initial
    begin
        repeat (WD_CYCLES) @(posedge clock);
        $display("Watchdog expired at %0t ns, the run did not finish in time", $time);
        $display("Checks failed");
        $finish;
    end

    function automatic logic [NB_APB_ADDR-1:0] word_addr(input logic [NB_APB_ADDR-1:0] base,
                                                         input int idx);
        return base + NB_APB_ADDR'(idx * (NB_APB_DATA / 8));
    endfunction

    function automatic logic [NB_APB_DATA-1:0] ctrl_word(input int bit_idx);
        return NB_APB_DATA'(1) << bit_idx;
    endfunction

    function automatic block_t rand_block();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic check_word(input string name, input logic [NB_APB_DATA-1:0] exp,
                              input logic [NB_APB_DATA-1:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            errors++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_block(input string name, input block_t exp, input block_t act);
        checks++;
        assert (act === exp)
        else
        begin
            errors++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic write_expect(input logic [NB_APB_ADDR-1:0] addr,
                                input logic [NB_APB_DATA-1:0] data, input logic want_err);
        logic err;
        apb_write(addr, data, err);
        check_word("pslverr", NB_APB_DATA'(want_err), NB_APB_DATA'(err));
    endtask

    task automatic write_block(input logic [NB_APB_ADDR-1:0] base, input block_t blk);
        // Word 0 carries bits 127:96.
        for (int w = 0; w < NB_WORDS_BLOCK; w++)
        begin
            write_expect(word_addr(base, w), blk[NB_BLOCK-1-w*NB_APB_DATA -: NB_APB_DATA], 1'b0);
        end
    endtask

    task automatic read_block(input logic [NB_APB_ADDR-1:0] base, output block_t blk);
        logic [NB_APB_DATA-1:0] word;
        logic                   err;
        blk = '0;
        for (int w = 0; w < NB_WORDS_BLOCK; w++)
        begin
            apb_read(word_addr(base, w), word, err);
            check_word("pslverr", '0, NB_APB_DATA'(err));
            blk[NB_BLOCK-1-w*NB_APB_DATA -: NB_APB_DATA] = word;
        end
    endtask

    // Poll STATUS until one bit reaches the wanted level.
    task automatic wait_status(input int bit_idx, input logic want, input string what);
        logic [NB_APB_DATA-1:0] status;
        logic                   err;
        int                     polls;
        polls = 1;
        apb_read(ADDR_STATUS, status, err);
        while (status[bit_idx] !== want && polls < POLL_LIMIT)
        begin
            apb_read(ADDR_STATUS, status, err);
            polls++;
        end
        checks++;
        assert (status[bit_idx] === want)
        else
        begin
            errors++;
            $display("Gave up waiting for %s after %0d status reads", what, polls);
        end
    endtask

    task automatic load_key(input block_t key);
        write_block(ADDR_KEY_BASE, key);
        write_expect(ADDR_CTRL, ctrl_word(CTRL_LOAD_BIT), 1'b0);
        wait_status(STAT_READY_BIT, 1'b1, "key_ready");
    endtask

    task automatic run_step(input block_t x1, input block_t x2);
        write_block(ADDR_DATA_BASE, x1);
        write_block(word_addr(ADDR_DATA_BASE, NB_WORDS_BLOCK), x2);
        write_expect(ADDR_CTRL, ctrl_word(CTRL_START_BIT), 1'b0);
        wait_status(STAT_BUSY_BIT, 1'b0, "busy to drop");
    endtask

    task automatic start_test(input string name);
        tests++;
        test_name = name;
        test_errs = errors;
    endtask

    task automatic end_test();
        if (errors == test_errs)
        begin
            $display("Test %0d %s: ok", tests, test_name);
        end
        else
        begin
            $display("Test %0d %s: %0d errors", tests, test_name, errors - test_errs);
        end
    endtask

    // Random rows first, then fixed keys and blocks on top.
    task automatic build_table();
        block_t h;
        block_t y;
        for (int r = 0; r < NROWS; r++)
        begin
            rows[r].key   = rand_block();
            rows[r].x1    = rand_block();
            rows[r].x2    = rand_block();
            rows[r].load  = 1'b0;
            rows[r].clear = 1'b0;
            rows[r].exp   = '0;
        end
        rows[0].load  = 1'b1;
        rows[0].clear = 1'b1;
        rows[0].key   = KEY_ONE;
        rows[1].x1    = '1;
        rows[2].load  = 1'b1;
        rows[2].key   = '0;
        rows[3].load  = 1'b1;
        rows[3].key   = '1;
        rows[3].x2    = '0;
        rows[6].load  = 1'b1;
        rows[6].clear = 1'b1;
        rows[10].clear = 1'b1;
        rows[11].load  = 1'b1;
        // Plain GHASH, one block at a time.
        h = '0;
        y = '0;
        for (int r = 0; r < NROWS; r++)
        begin
            if (rows[r].load)
            begin
                h = rows[r].key;
            end
            if (rows[r].clear)
            begin
                y = '0;
            end
            y = gf_mult(y ^ rows[r].x1, h);
            y = gf_mult(y ^ rows[r].x2, h);
            rows[r].exp = y;
        end
    endtask

    initial
    begin
        logic [NB_APB_DATA-1:0] word;
        logic                   err;
        block_t                 res;
        apb_req = '0;
        arst_n  = 1'b0;
        seed    = 32'h74be;
        errors  = 0;
        checks  = 0;
        tests   = 0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        arst_n = 1'b1;

        start_test("reset values");
        apb_read(ADDR_STATUS, word, err);
        check_word("status", '0, word);
        check_word("pslverr", '0, NB_APB_DATA'(err));
        read_block(ADDR_RESULT_BASE, res);
        check_block("result", '0, res);
        end_test();

        start_test("refused accesses");
        // Start with no key loaded.
        write_expect(ADDR_CTRL, ctrl_word(CTRL_START_BIT), 1'b1);
        write_expect(8'h08, 32'hdead_beef, 1'b1);
        apb_read(8'h80, word, err);
        check_word("pslverr", 32'd1, NB_APB_DATA'(err));
        write_expect(ADDR_STATUS, 32'h3, 1'b1);
        apb_read(ADDR_STATUS, word, err);
        check_word("status", '0, word);
        read_block(ADDR_RESULT_BASE, res);
        check_block("result", '0, res);
        end_test();

        // Accumulator carries over between rows unless cleared.
        for (int r = 0; r < NROWS; r++)
        begin
            start_test($sformatf("table row %0d", r));
            if (rows[r].load)
            begin
                load_key(rows[r].key);
            end
            if (rows[r].clear)
            begin
                write_expect(ADDR_CTRL, ctrl_word(CTRL_CLEAR_BIT), 1'b0);
                read_block(ADDR_RESULT_BASE, res);
                check_block("result after clear", '0, res);
            end
            run_step(rows[r].x1, rows[r].x2);
            read_block(ADDR_RESULT_BASE, res);
            check_block("result", rows[r].exp, res);
            end_test();
        end

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: verilog/gf128_mult.sv
`timescale 1ns/1ns

module gf128_mult
    import ghash_pkg::*;
(
    // Outputs.
    output block_t o_z,
    // Inputs.
    input  block_t i_a,
    input  block_t i_b,
    input  logic   i_arst_n,
    input  logic   i_clock
);

    // Operands in polynomial order with bit i as x^i.
    logic [NB_BLOCK-1:0]   a_poly;
    logic [NB_BLOCK-1:0]   b_poly;
    // Full carry-less product up to degree 254.
    logic [2*NB_BLOCK-2:0] prod;
    block_t                z_next;

    always_comb
    begin
        // GCM words are bit reflected.
        for (int i = 0; i < NB_BLOCK; i++)
        begin
            a_poly[i] = i_a[NB_BLOCK-1-i];
            b_poly[i] = i_b[NB_BLOCK-1-i];
        end

        // Shift and xor partial products.
        prod = '0;
        for (int i = 0; i < NB_BLOCK; i++)
        begin
            if (a_poly[i])
            begin
                prod[i +: NB_BLOCK] = prod[i +: NB_BLOCK] ^ b_poly;
            end
        end

        // Fold high terms down, top first.
        // Folded bits may land above x^127 again.
        for (int i = 2*NB_BLOCK-2; i >= NB_BLOCK; i--)
        begin
            if (prod[i])
            begin
                prod[i-NB_BLOCK +: NB_POLY_LOW] = prod[i-NB_BLOCK +: NB_POLY_LOW] ^ GCM_POLY_LOW;
            end
        end

        // Back to word order.
        for (int i = 0; i < NB_BLOCK; i++)
        begin
            z_next[NB_BLOCK-1-i] = prod[i];
        end
    end

    // Product registered, latency of one.
    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_z <= '0;
        end
        else
        begin
            o_z <= z_next;
        end
    end

    // No unknown bits on the product after reset.
    a_z_known: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        !$isunknown(o_z));

endmodule

// File: verilog/ghash_core.sv
`timescale 1ns/1ns

module ghash_core
    import ghash_pkg::*;
(
    // Outputs.
    output logic       o_busy,
    output block_t     o_hash,
    // Inputs.
    input  ghash_cmd_t i_cmd,
    input  h_powers_t  i_powers,
    input  logic       i_arst_n,
    input  logic       i_clock
);

    // Stage 0 has operands, stage 1 has products.
    logic [1:0] step_q;
    logic       step_go;
    block_t     acc_q;
    block_t     acc_src;
    // Operands for the H^2 branch.
    block_t     op_hi_a_q;
    block_t     op_hi_b_q;
    // Operands for the H^1 branch.
    block_t     op_lo_a_q;
    block_t     op_lo_b_q;
    block_t     prod_hi;
    block_t     prod_lo;

    // Starts are only taken when idle.
    assign step_go = i_cmd.start && !o_busy;
    // A clear in the same cycle hashes from zero.
    assign acc_src = i_cmd.clear ? '0 : acc_q;

    // (Y xor X1) times H^2.
    gf128_mult u_gf128_mult_hi
    (
        .o_z      (prod_hi),
        .i_a      (op_hi_a_q),
        .i_b      (op_hi_b_q),
        .i_arst_n (i_arst_n),
        .i_clock  (i_clock)
    );

    // X2 times H.
    gf128_mult u_gf128_mult_lo
    (
        .o_z      (prod_lo),
        .i_a      (op_lo_a_q),
        .i_b      (op_lo_b_q),
        .i_arst_n (i_arst_n),
        .i_clock  (i_clock)
    );

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            step_q    <= '0;
            acc_q     <= '0;
            op_hi_a_q <= '0;
            op_hi_b_q <= '0;
            op_lo_a_q <= '0;
            op_lo_b_q <= '0;
        end
        else
        begin
            step_q <= {step_q[0], step_go};

            if (step_go)
            begin
                op_hi_a_q <= acc_src ^ i_cmd.x1;
                op_hi_b_q <= i_powers.h2;
                op_lo_a_q <= i_cmd.x2;
                op_lo_b_q <= i_powers.h1;
            end

            // Products valid in the second stage.
            if (step_q[1])
            begin
                acc_q <= prod_hi ^ prod_lo;
            end
            else if (i_cmd.clear)
            begin
                acc_q <= '0;
            end
        end
    end

    assign o_busy = |step_q;
    assign o_hash = acc_q;

    // Register block holds back commands while a step runs.
    a_no_cmd_busy: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        o_busy |-> !(i_cmd.start || i_cmd.clear));

endmodule

// File: verilog/ghash_pkg.sv
package ghash_pkg;

    // Field element width and blocks folded per step.
    localparam int NB_BLOCK      = 128;
    localparam int NB_BLOCKS_AGG = 2;

    // Low terms of the GCM reduction polynomial.
    localparam int                     NB_POLY_LOW  = 8;
    localparam logic [NB_POLY_LOW-1:0] GCM_POLY_LOW = 8'h87;

    // APB bus widths.
    localparam int NB_APB_ADDR = 8;
    localparam int NB_APB_DATA = 32;

    // Word indexing of blocks behind the bus.
    localparam int NB_BYTE_IDX    = $clog2(NB_APB_DATA / 8);
    localparam int NB_WORDS_BLOCK = NB_BLOCK / NB_APB_DATA;
    localparam int NB_WORD_IDX    = $clog2(NB_WORDS_BLOCK);
    localparam int NB_DATA_IDX    = $clog2(NB_WORDS_BLOCK * NB_BLOCKS_AGG);

    // Register map.
    localparam logic [NB_APB_ADDR-1:0] ADDR_CTRL        = 8'h00;
    localparam logic [NB_APB_ADDR-1:0] ADDR_STATUS      = 8'h04;
    localparam logic [NB_APB_ADDR-1:0] ADDR_KEY_BASE    = 8'h10;
    localparam logic [NB_APB_ADDR-1:0] ADDR_DATA_BASE   = 8'h20;
    localparam logic [NB_APB_ADDR-1:0] ADDR_RESULT_BASE = 8'h40;

    // CTRL pulse bits.
    localparam int CTRL_LOAD_BIT  = 0;
    localparam int CTRL_START_BIT = 1;
    localparam int CTRL_CLEAR_BIT = 2;
    // STATUS bits.
    localparam int STAT_READY_BIT = 0;
    localparam int STAT_BUSY_BIT  = 1;

    typedef logic [NB_BLOCK-1:0] block_t;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [NB_APB_ADDR-1:0] paddr;
        logic [NB_APB_DATA-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [NB_APB_DATA-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_rsp_t;

    // One aggregated step request.
    typedef struct packed {
        logic   start;
        logic   clear;
        block_t x1;
        block_t x2;
    } ghash_cmd_t;

    typedef struct packed {
        block_t h1;
        block_t h2;
    } h_powers_t;

endpackage

// File: verilog/ghash_regs.sv
`timescale 1ns/1ns

module ghash_regs
    import ghash_pkg::*;
(
    // Outputs.
    output apb_rsp_t   o_apb,
    output block_t     o_key,
    output logic       o_load,
    output ghash_cmd_t o_cmd,
    // Inputs.
    input  apb_req_t   i_apb,
    input  logic       i_ready,
    input  logic       i_busy,
    input  block_t     i_hash,
    input  logic       i_arst_n,
    input  logic       i_clock
);

    block_t                    key_q;
    block_t                    data_q [NB_BLOCKS_AGG];
    logic                      access;
    logic                      wr;
    // Offsets from each window base.
    logic [NB_APB_ADDR-1:0]    key_off;
    logic [NB_APB_ADDR-1:0]    data_off;
    logic [NB_APB_ADDR-1:0]    res_off;
    logic                      aligned;
    logic                      ctrl_hit;
    logic                      status_hit;
    logic                      key_hit;
    logic                      data_hit;
    logic                      res_hit;
    logic [NB_WORD_IDX-1:0]    key_word;
    logic [NB_WORD_IDX-1:0]    res_word;
    logic [NB_DATA_IDX-1:0]    data_word;
    logic [NB_DATA_IDX-NB_WORD_IDX-1:0] data_blk;
    logic                      req_load;
    logic                      req_start;
    logic                      req_clear;
    logic                      cmd_err;
    logic                      err;

    // Word 0 is the top of the block.
    function automatic logic [NB_APB_DATA-1:0] word_sel(input block_t blk,
                                                        input logic [NB_WORD_IDX-1:0] idx);
        return blk[NB_BLOCK-1-idx*NB_APB_DATA -: NB_APB_DATA];
    endfunction

    always_comb
    begin
        access   = i_apb.psel && i_apb.penable;
        wr       = access && i_apb.pwrite;
        key_off  = i_apb.paddr - ADDR_KEY_BASE;
        data_off = i_apb.paddr - ADDR_DATA_BASE;
        res_off  = i_apb.paddr - ADDR_RESULT_BASE;
        aligned  = i_apb.paddr[NB_BYTE_IDX-1:0] == '0;

        // Wrapped offsets below a base fall out of range.
        ctrl_hit   = i_apb.paddr == ADDR_CTRL;
        status_hit = i_apb.paddr == ADDR_STATUS;
        key_hit    = aligned && key_off < (NB_WORDS_BLOCK << NB_BYTE_IDX);
        data_hit   = aligned && data_off < ((NB_WORDS_BLOCK * NB_BLOCKS_AGG) << NB_BYTE_IDX);
        res_hit    = aligned && res_off < (NB_WORDS_BLOCK << NB_BYTE_IDX);

        key_word  = key_off[NB_BYTE_IDX +: NB_WORD_IDX];
        res_word  = res_off[NB_BYTE_IDX +: NB_WORD_IDX];
        data_word = data_off[NB_BYTE_IDX +: NB_DATA_IDX];
        data_blk  = data_word[NB_DATA_IDX-1:NB_WORD_IDX];

        // Command requests from a CTRL write.
        req_load  = wr && ctrl_hit && i_apb.pwdata[CTRL_LOAD_BIT];
        req_start = wr && ctrl_hit && i_apb.pwdata[CTRL_START_BIT];
        req_clear = wr && ctrl_hit && i_apb.pwdata[CTRL_CLEAR_BIT];

        // Start needs a key and an idle core.
        cmd_err = (req_start && (!i_ready || i_busy)) || ((req_load || req_clear) && i_busy);

        err = (access && !(ctrl_hit || status_hit || key_hit || data_hit || res_hit))
            || (wr && (status_hit || res_hit))
            || cmd_err;
    end

    // Any refused bit drops the whole write.
    assign o_load    = req_load && !cmd_err;
    assign o_cmd     = '{start: req_start && !cmd_err, clear: req_clear && !cmd_err,
                         x1: data_q[0], x2: data_q[1]};
    assign o_key     = key_q;

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            key_q <= '0;
            for (int b = 0; b < NB_BLOCKS_AGG; b++)
            begin
                data_q[b] <= '0;
            end
        end
        else if (wr && key_hit)
        begin
            key_q[NB_BLOCK-1-key_word*NB_APB_DATA -: NB_APB_DATA] <= i_apb.pwdata;
        end
        else if (wr && data_hit)
        begin
            data_q[data_blk][NB_BLOCK-1-data_word[NB_WORD_IDX-1:0]*NB_APB_DATA -: NB_APB_DATA]
                <= i_apb.pwdata;
        end
    end

    always_comb
    begin
        o_apb.prdata  = '0;
        o_apb.pready  = 1'b1;
        o_apb.pslverr = err;
        // CTRL reads back as zero.
        if (status_hit)
        begin
            o_apb.prdata[STAT_READY_BIT] = i_ready;
            o_apb.prdata[STAT_BUSY_BIT]  = i_busy;
        end
        else if (key_hit)
        begin
            o_apb.prdata = word_sel(key_q, key_word);
        end
        else if (data_hit)
        begin
            o_apb.prdata = word_sel(data_q[data_blk], data_word[NB_WORD_IDX-1:0]);
        end
        else if (res_hit)
        begin
            o_apb.prdata = word_sel(i_hash, res_word);
        end
    end

    // Access phase follows a setup phase to the same address.
    a_apb_setup: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        access |-> $past(i_apb.psel && !i_apb.penable) && $stable(i_apb.paddr));

endmodule

// File: verilog/ghash_top.sv
`timescale 1ns/1ns

module ghash_top
    import ghash_pkg::*;
(
    // Outputs.
    output apb_rsp_t o_apb,
    // Inputs.
    input  apb_req_t i_apb,
    input  logic     i_arst_n,
    input  logic     i_clock
);

    // Key path.
    block_t     key;
    logic       load;
    h_powers_t  powers;
    logic       key_ready;
    // Hash path.
    ghash_cmd_t cmd;
    logic       busy;
    block_t     hash;

    ghash_regs u_ghash_regs
    (
        .o_apb    (o_apb),
        .o_key    (key),
        .o_load   (load),
        .o_cmd    (cmd),
        .i_apb    (i_apb),
        .i_ready  (key_ready),
        .i_busy   (busy),
        .i_hash   (hash),
        .i_arst_n (i_arst_n),
        .i_clock  (i_clock)
    );

    h_key_power_table u_h_key_power_table
    (
        .o_powers (powers),
        .o_ready  (key_ready),
        .i_key    (key),
        .i_load   (load),
        .i_arst_n (i_arst_n),
        .i_clock  (i_clock)
    );

    // Powers go straight from the table to the core.
    ghash_core u_ghash_core
    (
        .o_busy   (busy),
        .o_hash   (hash),
        .i_cmd    (cmd),
        .i_powers (powers),
        .i_arst_n (i_arst_n),
        .i_clock  (i_clock)
    );

endmodule

// File: verilog/h_key_power_table.sv
`timescale 1ns/1ns

module h_key_power_table
    import ghash_pkg::*;
(
    // Outputs.
    output h_powers_t o_powers,
    output logic      o_ready,
    // Inputs.
    input  block_t    i_key,
    input  logic      i_load,
    input  logic      i_arst_n,
    input  logic      i_clock
);

    // Load travels through two stages before H^2 is valid.
    logic [1:0] phase_q;
    block_t     h_sq;

    // H times H.
    gf128_mult u_gf128_mult_sq
    (
        .o_z      (h_sq),
        .i_a      (o_powers.h1),
        .i_b      (o_powers.h1),
        .i_arst_n (i_arst_n),
        .i_clock  (i_clock)
    );

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            phase_q  <= '0;
            o_powers <= '0;
            o_ready  <= 1'b0;
        end
        else
        begin
            // A new load restarts the sequence.
            phase_q <= {phase_q[0] & ~i_load, i_load};

            if (i_load)
            begin
                o_powers.h1 <= i_key;
                o_ready     <= 1'b0;
            end
            else if (phase_q[1])
            begin
                // Square of the stored key.
                o_powers.h2 <= h_sq;
                o_ready     <= 1'b1;
            end
        end
    end

    // Ready only rises two edges after the load edge.
    a_ready_after_load: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        $rose(o_ready) |-> $past(i_load, 3));

endmodule
